// ==== include/spriteFast_consts.svh ====
`ifndef SPRITEFAST_CONSTS_SVH
`define SPRITEFAST_CONSTS_SVH

// Frame windows, in CLK_24M slots
`define SF_SLOT_LIST  5'd0
`define SF_SLOT_SCB2  5'd4
`define SF_SLOT_SCB3  5'd7
`define SF_SLOT_SCB4  5'd10
`define SF_SLOT_CPU   5'd13
// Five windows of three slots each
`define SF_SLOT_PARSE 5'd16
`define SF_SLOT_IDLE  5'd31

// Fast VRAM map
`define SF_VRAM_WORDS 2048
`define SF_SCB2_BASE  11'h000
`define SF_SCB3_BASE  11'h200
`define SF_SCB4_BASE  11'h400
`define SF_LIST_BASE  11'h600

`endif

// ==== verilog/spriteFastPkg.sv ====
package spriteFastPkg;

	// Fast VRAM word address
	typedef logic [10:0] vramAddrT;
	// Fast VRAM word
	typedef logic [15:0] vramDataT;
	// Sprite number, 0 to 511
	typedef logic [8:0] spriteIdxT;
	// Position inside the 32-cycle frame
	typedef logic [4:0] slotT;
	// Line count or render line
	typedef logic [8:0] lineT;
	// Active list entry, one bank
	typedef logic [6:0] listPtrT;

	// Parser pair machine
	typedef enum logic [1:0] {
		latchA,	// Looking for first match
		latchB,	// Looking for second match
		writeA,	// Store first of pair
		writeB	// Store second of pair
	} parseStateT;

endpackage

// ==== verilog/fastVram.sv ====
`timescale 1ns/1ps
`include "spriteFast_consts.svh"

module fastVram (
	input logic CLK_24M,
	input spriteFastPkg::vramAddrT addr,
	input spriteFastPkg::vramDataT wrData,
	input logic we,
	output spriteFastPkg::vramDataT rdData
);

	import spriteFastPkg::*;

	// SCB2/3/4 tables and both list banks
	vramDataT mem [0:`SF_VRAM_WORDS-1];

	// Read-first, one cycle latency
	always_ff @(posedge CLK_24M)
	begin
		rdData <= mem[addr];	// Old word even when writing
		if (we)
			mem[addr] <= wrData;
	end

	// A write to an unknown address would corrupt the whole array
	addrKnownOnWrite: assert property (
		@(posedge CLK_24M) we |-> !$isunknown(addr)
	);

endmodule

// ==== verilog/fastBusArbiter.sv ====
`timescale 1ns/1ps
`include "spriteFast_consts.svh"

module fastBusArbiter (
	input logic CLK_24M,
	input logic TEST,
	output spriteFastPkg::slotT slot,
	input spriteFastPkg::vramAddrT cpuAddrBus,
	input spriteFastPkg::vramAddrT parseAddr,
	input spriteFastPkg::vramAddrT renderAddr,
	input spriteFastPkg::vramDataT cpuWrBus,
	input spriteFastPkg::vramDataT parseWrData,
	input logic cpuWe,
	input logic parseWe,
	output spriteFastPkg::vramAddrT vramAddr,
	output spriteFastPkg::vramDataT vramWrData,
	output logic vramWe
);

	logic inRender;	// List, SCB2, SCB3, SCB4
	logic inCpu;
	logic inParse;	// Slot 31 excluded

	// Free-running frame counter, wraps at 31
	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
			slot <= `SF_SLOT_LIST;
		else
			slot <= slot + 5'd1;
	end

	assign inRender = slot < `SF_SLOT_CPU;
	assign inCpu = (slot >= `SF_SLOT_CPU) && (slot < `SF_SLOT_PARSE);
	assign inParse = (slot >= `SF_SLOT_PARSE) && (slot != `SF_SLOT_IDLE);

	// Port owner by window
	always_comb
	begin
		if (inRender)
			vramAddr = renderAddr;
		else if (inCpu)
			vramAddr = cpuAddrBus;
		else
			vramAddr = parseAddr;	// Idle slot parks here too
		vramWrData = inCpu ? cpuWrBus : parseWrData;
		vramWe = (inCpu & cpuWe) | (inParse & parseWe);	// Render side never writes
	end

	// CPU writes stop before slot 15, parse writes never reach the idle slot
	weInWriteWindows: assert property (
		@(posedge CLK_24M) disable iff (TEST)
		vramWe |-> ((slot >= `SF_SLOT_CPU) && (slot < `SF_SLOT_CPU + 5'd2))
			|| ((slot >= `SF_SLOT_PARSE) && (slot < `SF_SLOT_IDLE))
	);

endmodule

// ==== verilog/cpuPort.sv ====
`timescale 1ns/1ps
`include "spriteFast_consts.svh"

module cpuPort (
	input logic CLK_24M,
	input logic TEST,
	input spriteFastPkg::slotT slot,
	input spriteFastPkg::vramAddrT cpuAddr,
	input spriteFastPkg::vramAddrT vramMod,
	input spriteFastPkg::vramDataT cpuWrData,
	input logic cpuZone,
	input logic cpuWrite,
	input logic reloadReq,
	input spriteFastPkg::vramDataT rdData,
	output spriteFastPkg::vramAddrT cpuAddrBus,
	output spriteFastPkg::vramDataT cpuWrBus,
	output logic cpuWe,
	output spriteFastPkg::vramDataT cpuRdData,
	output logic cpuWriteAck
);

	import spriteFastPkg::*;

	vramAddrT ptr;		// CPU VRAM pointer
	logic reloadPend;	// Reload seen, not yet applied
	logic writeFrame;	// This frame's CPU slot writes

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			ptr <= '0;
			reloadPend <= 1'b0;
			writeFrame <= 1'b0;
			cpuRdData <= '0;
			cpuWriteAck <= 1'b0;
		end
		else
		begin
			cpuWriteAck <= (slot == `SF_SLOT_CPU + 5'd1) && writeFrame;	// Lands in slot 15
			if (slot == `SF_SLOT_CPU - 5'd2)
			begin
				// End of slot 11, CPU setup
				if (reloadPend)
					ptr <= cpuAddr;
				reloadPend <= reloadReq;	// Pulse on this edge waits a frame
				writeFrame <= cpuWrite & cpuZone;
			end
			else if (reloadReq)
				reloadPend <= 1'b1;
			if (slot == `SF_SLOT_CPU + 5'd1)
			begin
				cpuRdData <= rdData;	// Word at ptr from slot 13
				if (writeFrame)
					ptr <= ptr + vramMod;	// Wraps at 2048
			end
		end
	end

	assign cpuAddrBus = ptr;
	assign cpuWrBus = cpuWrData;
	assign cpuWe = writeFrame && ((slot == `SF_SLOT_CPU) || (slot == `SF_SLOT_CPU + 5'd1));

	// Ack follows the write strobe by one slot
	ackAfterWrite: assert property (
		@(posedge CLK_24M) disable iff (TEST)
		cpuWriteAck |-> (slot == `SF_SLOT_CPU + 5'd2) && $past(cpuWe)
	);

endmodule

// ==== verilog/spriteParser.sv ====
`timescale 1ns/1ps
`include "spriteFast_consts.svh"

module spriteParser (
	input logic CLK_24M,
	input logic TEST,
	input spriteFastPkg::slotT slot,
	input spriteFastPkg::lineT vCount,
	input logic chbl,
	input logic bufFlip,
	input spriteFastPkg::vramDataT rdData,
	output spriteFastPkg::vramAddrT parseAddr,
	output spriteFastPkg::vramDataT parseWrData,
	output logic parseWe
);

	import spriteFastPkg::*;

	parseStateT state;
	spriteIdxT parseCnt;	// Sprite being scanned
	spriteIdxT spriteLatchA;
	spriteIdxT spriteLatchB;
	listPtrT listPtr;		// Next free list entry
	logic parseWin;
	logic parseEnd;		// Third slot of a parse window
	logic writing;
	logic [8:0] ySum;
	logic match;

	// Y carry rule, height ignored
	assign ySum = {1'b0, rdData[14:7]} + {1'b0, vCount[7:0]} + 9'd1;
	assign match = ySum[8] ^ rdData[15];	// Bit 15 is spriteY[8]

	assign parseWin = (slot >= `SF_SLOT_PARSE) && (slot != `SF_SLOT_IDLE);
	always_comb
	begin
		case (slot)
			`SF_SLOT_PARSE + 5'd2, `SF_SLOT_PARSE + 5'd5, `SF_SLOT_PARSE + 5'd8,
			`SF_SLOT_PARSE + 5'd11, `SF_SLOT_PARSE + 5'd14:
				parseEnd = 1'b1;
			default:
				parseEnd = 1'b0;
		endcase
	end

	assign writing = (state == writeA) || (state == writeB);
	assign parseWe = writing && parseWin && !parseEnd;	// First two slots of the window

	// List bank opposite to the one render walks
	assign parseAddr = writing ? `SF_LIST_BASE + {3'd0, ~bufFlip, listPtr}
		: `SF_SCB3_BASE + {2'd0, parseCnt};
	assign parseWrData = {7'd0, (state == writeA) ? spriteLatchA : spriteLatchB};

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			state <= latchA;
			parseCnt <= '0;
			listPtr <= '0;
		end
		else if ((slot == `SF_SLOT_IDLE) && chbl)
		begin
			// New line
			state <= latchA;
			parseCnt <= '0;
			listPtr <= '0;
		end
		else if (parseEnd)
		begin
			case (state)
				latchA:
				begin
					parseCnt <= parseCnt + 9'd1;
					if (match)
						state <= latchB;
				end
				latchB:
				begin
					parseCnt <= parseCnt + 9'd1;
					if (match)
						state <= writeA;
				end
				writeA:
				begin
					listPtr <= listPtr + 7'd1;
					state <= writeB;
				end
				default:
				begin
					listPtr <= listPtr + 7'd1;
					state <= latchA;	// Pair done
				end
			endcase
		end
	end

	// Matched sprite numbers
	always_ff @(posedge CLK_24M)
	begin
		if (parseEnd && match && (state == latchA))
			spriteLatchA <= parseCnt;
		if (parseEnd && match && (state == latchB))
			spriteLatchB <= parseCnt;
	end

	// A list write only ever stores a sprite number that a match has latched
	latchKnownOnWrite: assert property (
		@(posedge CLK_24M) disable iff (TEST)
		parseWe |-> !$isunknown(parseWrData)
	);

endmodule

// ==== verilog/renderFetch.sv ====
`timescale 1ns/1ps
`include "spriteFast_consts.svh"

module renderFetch (
	input logic CLK_24M,
	input logic TEST,
	input spriteFastPkg::slotT slot,
	input spriteFastPkg::lineT vCount,
	input logic chbl,
	input logic bufFlip,
	input spriteFastPkg::vramDataT rdData,
	output spriteFastPkg::vramAddrT renderAddr,
	output spriteFastPkg::spriteIdxT renderIdx,
	output logic [11:0] attrShrink,
	output logic [4:0] tileIdx,
	output logic [3:0] tileLine,
	output logic [8:0] attrXpos
);

	import spriteFastPkg::*;

	listPtrT readPtr;		// Entry in bank bufFlip
	lineT renderLine;

	assign renderLine = {1'b0, rdData[14:7]} + {1'b0, vCount[7:0]};	// spriteY + line

	// Address per render window
	always_comb
	begin
		if (slot < `SF_SLOT_SCB2)
			renderAddr = `SF_LIST_BASE + {3'd0, bufFlip, readPtr};
		else if (slot < `SF_SLOT_SCB3)
			renderAddr = `SF_SCB2_BASE + {2'd0, renderIdx};
		else if (slot < `SF_SLOT_SCB4)
			renderAddr = `SF_SCB3_BASE + {2'd0, renderIdx};
		else
			renderAddr = `SF_SCB4_BASE + {2'd0, renderIdx};
	end

	always_ff @(posedge CLK_24M or posedge TEST)
	begin
		if (TEST)
		begin
			readPtr <= '0;
			renderIdx <= '0;
			attrShrink <= '0;
			tileIdx <= '0;
			tileLine <= '0;
			attrXpos <= '0;
		end
		else
		begin
			case (slot)
				`SF_SLOT_LIST + 5'd2: renderIdx <= rdData[8:0];	// List entry
				`SF_SLOT_SCB2 + 5'd1: attrShrink <= rdData[11:0];
				`SF_SLOT_SCB3 + 5'd1:
				begin
					tileIdx <= renderLine[8:4];
					tileLine <= renderLine[3:0];
				end
				`SF_SLOT_SCB4 + 5'd1:
				begin
					attrXpos <= rdData[15:7];
					readPtr <= readPtr + 7'd1;	// Next sprite next frame
				end
				`SF_SLOT_IDLE:
					if (chbl)
						readPtr <= '0;
				default: ;
			endcase
		end
	end

endmodule

// ==== verilog/spriteFast.sv ====
`timescale 1ns/1ps

module spriteFast (
	input logic CLK_24M,
	input logic TEST,
	input spriteFastPkg::lineT vCount,
	input logic chbl,
	input logic bufFlip,
	input spriteFastPkg::vramAddrT cpuAddr,
	input spriteFastPkg::vramDataT cpuWrData,
	input logic cpuZone,
	input logic cpuWrite,
	input logic reloadReq,
	input spriteFastPkg::vramAddrT vramMod,
	output spriteFastPkg::vramDataT cpuRdData,
	output logic cpuWriteAck,
	output spriteFastPkg::spriteIdxT renderIdx,
	output logic [11:0] attrShrink,
	output logic [4:0] tileIdx,
	output logic [3:0] tileLine,
	output logic [8:0] attrXpos
);

	import spriteFastPkg::*;

	slotT slot;
	vramAddrT cpuAddrBus, parseAddr, renderAddr, vramAddr;
	vramDataT cpuWrBus, parseWrData, vramWrData, rdData;
	logic cpuWe, parseWe, vramWe;

	// Slot owner and port mux
	fastBusArbiter u_arbiter (.CLK_24M, .TEST, .slot, .cpuAddrBus, .parseAddr, .renderAddr,
		.cpuWrBus, .parseWrData, .cpuWe, .parseWe, .vramAddr, .vramWrData, .vramWe);

	cpuPort u_cpuPort (.CLK_24M, .TEST, .slot, .cpuAddr, .vramMod, .cpuWrData, .cpuZone,
		.cpuWrite, .reloadReq, .rdData, .cpuAddrBus, .cpuWrBus, .cpuWe, .cpuRdData, .cpuWriteAck);

	// Fills the back list bank
	spriteParser u_parser (.CLK_24M, .TEST, .slot, .vCount, .chbl, .bufFlip, .rdData,
		.parseAddr, .parseWrData, .parseWe);

	renderFetch u_render (.CLK_24M, .TEST, .slot, .vCount, .chbl, .bufFlip, .rdData,
		.renderAddr, .renderIdx, .attrShrink, .tileIdx, .tileLine, .attrXpos);

	fastVram u_vram (.CLK_24M, .addr(vramAddr), .wrData(vramWrData), .we(vramWe), .rdData);

endmodule

// ==== test/spriteFastTb.sv ====
`timescale 1ns/1ps
`include "spriteFast_consts.svh"

module spriteFastTb;

	import spriteFastPkg::*;

	localparam int RAND_FRAMES = 48;	// Scattered CPU traffic
	localparam int NSPR = 24;		// Sprites with loaded tables
	localparam int LIST_FILL = 16;	// Preloaded entries per bank
	localparam int NLINES = 12;
	localparam int LINE_FRAMES = 18;	// Last 6 frames read back the list
	localparam int FRAMES = RAND_FRAMES + 3 * NSPR + 2 * LIST_FILL + NLINES * LINE_FRAMES;
	localparam int CYCLE_LIMIT = (FRAMES + 4) * 32 + 16;	// Reset and margin included

	logic CLK_24M;
	logic TEST;
	lineT vCount;
	logic chbl;
	logic bufFlip;
	vramAddrT cpuAddr;
	vramDataT cpuWrData;
	logic cpuZone;
	logic cpuWrite;
	logic reloadReq;
	vramAddrT vramMod;
	vramDataT cpuRdData;
	logic cpuWriteAck;
	spriteIdxT renderIdx;
	logic [11:0] attrShrink;
	logic [4:0] tileIdx;
	logic [3:0] tileLine;
	logic [8:0] attrXpos;

	vramDataT modelMem [0:`SF_VRAM_WORDS-1];	// Unwritten words stay X
	slotT tbSlot;		// Slot that ends at the current edge
	vramAddrT mPtr;
	logic mPend;
	logic mWrite;
	parseStateT pState;
	spriteIdxT pCnt;
	spriteIdxT pA;
	spriteIdxT pB;
	listPtrT lPtr;	// Parser list pointer
	listPtrT rPtr;	// Render read pointer
	vramDataT word;
	logic hit;
	vramDataT expRd;
	vramDataT expShrink;
	vramDataT expXpos;
	spriteIdxT expIdx;
	lineT expLine;
	logic expAck;
	logic curFlip;
	int errCnt = 0;
	int cycleCnt = 0;

	spriteFast i_dut (.CLK_24M, .TEST, .vCount, .chbl, .bufFlip, .cpuAddr, .cpuWrData,
		.cpuZone, .cpuWrite, .reloadReq, .vramMod, .cpuRdData, .cpuWriteAck, .renderIdx,
		.attrShrink, .tileIdx, .tileLine, .attrXpos);

	initial
	begin
		CLK_24M = 1'b0;
		forever #4 CLK_24M = ~CLK_24M;	// 8 ns period
	end

	// Y carry rule, sprite height not used
	function automatic logic yMatch(input vramDataT scb3, input lineT line);
		logic [8:0] sum;
		sum = {1'b0, scb3[14:7]} + {1'b0, line[7:0]} + 9'd1;
		return sum[8] ^ scb3[15];
	endfunction

	task automatic failMismatch(input string name, input logic [15:0] got, input logic [15:0] exp);
		errCnt++;
		$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compareWord(input string name, input vramDataT got, input vramDataT exp);
		if (!$isunknown(exp) && (got !== exp))	// X means never written
			failMismatch(name, got, exp);
	endtask

	task automatic verifyIdx(input spriteIdxT got, input spriteIdxT exp);
		if (!$isunknown(exp) && (got !== exp))
			failMismatch("renderIdx", {7'd0, got}, {7'd0, exp});
	endtask

	task automatic checkTileLine(input lineT got, input lineT exp);
		if (!$isunknown(exp) && (got !== exp))
			failMismatch("tileIdx/tileLine", {7'd0, got}, {7'd0, exp});
	endtask

	task automatic ackExpected(input logic got, input logic exp);
		if (got !== exp)
			failMismatch("cpuWriteAck", {15'd0, got}, {15'd0, exp});
	endtask

	task automatic waitSlotEnd(input slotT s);
		@(posedge CLK_24M);
		while (tbSlot != s)
			@(posedge CLK_24M);
	endtask

	// One 32-slot frame of CPU setup, optional line start at its end
	task automatic runFrame(input logic reload, input vramAddrT addr, input logic wr,
		input logic zone, input vramDataT data, input vramAddrT mod, input logic lineEnd);
		waitSlotEnd(5'd0);
		reloadReq <= reload;	// One-cycle pulse in slot 1
		cpuAddr <= addr;
		cpuWrite <= wr;
		cpuZone <= zone;
		cpuWrData <= data;
		vramMod <= mod;
		waitSlotEnd(5'd1);
		reloadReq <= 1'b0;
		waitSlotEnd(5'd30);
		chbl <= lineEnd;	// Seen at the end of slot 31
		waitSlotEnd(5'd31);
		chbl <= 1'b0;
		if (lineEnd)
		begin
			vCount <= lineT'($urandom_range(0, 511));
			curFlip = ~curFlip;	// Swap banks every line
			bufFlip <= curFlip;
		end
	endtask

	// Reference frame model, evaluated at each slot end
	always @(posedge CLK_24M)
	begin
		if (TEST)
		begin
			tbSlot <= 5'd0;
			mPtr = '0;
			mPend = 1'b0;
			mWrite = 1'b0;
			pState = latchA;
			pCnt = '0;
			lPtr = '0;
			rPtr = '0;
			{expRd, expShrink, expXpos, expIdx, expLine, expAck} = '0;
		end
		else
		begin
			expAck = (tbSlot == 5'd14) && mWrite;	// High through slot 15
			if (tbSlot == 5'd11)
			begin
				if (mPend)
					mPtr = cpuAddr;
				mPend = reloadReq;
				mWrite = cpuWrite && cpuZone;
			end
			else if (reloadReq)
				mPend = 1'b1;
			if (tbSlot == 5'd14)
			begin
				expRd = modelMem[mPtr];	// Old word on a write frame
				if (mWrite)
				begin
					modelMem[mPtr] = cpuWrData;
					mPtr = mPtr + vramMod;
				end
			end
			if ((tbSlot == 5'd31) && chbl)
			begin
				pState = latchA;
				pCnt = '0;
				lPtr = '0;
				rPtr = '0;
			end
			else if ((tbSlot >= 5'd16) && (tbSlot <= 5'd30) && ((tbSlot - 5'd16) % 3 == 2))
			begin
				case (pState)
					latchA, latchB:
					begin
						hit = yMatch(modelMem[`SF_SCB3_BASE + {2'd0, pCnt}], vCount);
						if (hit && (pState == latchA))
						begin
							pA = pCnt;
							pState = latchB;
						end
						else if (hit)
						begin
							pB = pCnt;
							pState = writeA;
						end
						pCnt = pCnt + 9'd1;
					end
					writeA:
					begin
						modelMem[`SF_LIST_BASE + {3'd0, ~bufFlip, lPtr}] = {7'd0, pA};
						lPtr = lPtr + 7'd1;
						pState = writeB;
					end
					default:
					begin
						modelMem[`SF_LIST_BASE + {3'd0, ~bufFlip, lPtr}] = {7'd0, pB};
						lPtr = lPtr + 7'd1;
						pState = latchA;
					end
				endcase
			end
			case (tbSlot)
				5'd2: expIdx = modelMem[`SF_LIST_BASE + {3'd0, bufFlip, rPtr}][8:0];
				5'd5:
				begin
					word = modelMem[`SF_SCB2_BASE + {2'd0, expIdx}];
					expShrink = {4'd0, word[11:0]};
				end
				5'd8:
				begin
					word = modelMem[`SF_SCB3_BASE + {2'd0, expIdx}];
					expLine = {1'b0, word[14:7]} + {1'b0, vCount[7:0]};
				end
				5'd11:
				begin
					word = modelMem[`SF_SCB4_BASE + {2'd0, expIdx}];
					expXpos = {7'd0, word[15:7]};
					rPtr = rPtr + 7'd1;
				end
				default: ;
			endcase
			tbSlot <= tbSlot + 5'd1;
		end
	end

	// Outputs settle between edges
	always @(negedge CLK_24M)
	begin
		if (!TEST)
		begin
			compareWord("cpuRdData", cpuRdData, expRd);
			compareWord("attrShrink", {4'd0, attrShrink}, expShrink);
			compareWord("attrXpos", {7'd0, attrXpos}, expXpos);
			verifyIdx(renderIdx, expIdx);
			checkTileLine({tileIdx, tileLine}, expLine);
			ackExpected(cpuWriteAck, expAck);
		end
	end

	always @(posedge CLK_24M)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt == CYCLE_LIMIT)
		begin
			$display("Timeout: stimulus still running after %0d cycles", cycleCnt);
			$display("Testbench failed");
			$fatal(1, "Run stopped by timeout");
		end
	end

	initial
	begin
		void'($urandom(70055));
		TEST = 1'b1;
		vCount = '0;
		chbl = 1'b0;
		bufFlip = 1'b0;
		curFlip = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuZone = 1'b0;
		cpuWrite = 1'b0;
		reloadReq = 1'b0;
		vramMod = '0;
		repeat (8) @(posedge CLK_24M);
		TEST <= 1'b0;
		// Random writes and reads around $100, reload every fourth frame
		for (int i = 0; i < RAND_FRAMES; i++)
			runFrame((i % 4) == 0, vramAddrT'(11'h100 + $urandom_range(0, 63)),
				$urandom_range(0, 1), $urandom_range(0, 3) != 0, vramDataT'($urandom),
				vramAddrT'($urandom_range(1, 3)), 1'b0);
		// SCB2, SCB3 and SCB4 rows of the first sprites
		for (int t = 0; t < 3; t++)
			for (int i = 0; i < NSPR; i++)
				runFrame(i == 0, (t == 0) ? `SF_SCB2_BASE : (t == 1) ? `SF_SCB3_BASE
					: `SF_SCB4_BASE, 1'b1, 1'b1, vramDataT'($urandom), 11'd1, 1'b0);
		// Both list banks, last write starts the first line
		for (int b = 0; b < 2; b++)
			for (int i = 0; i < LIST_FILL; i++)
				runFrame(i == 0, `SF_LIST_BASE + vramAddrT'(b * 128), 1'b1, 1'b1,
					vramDataT'($urandom_range(0, NSPR - 1)), 11'd1,
					(b == 1) && (i == LIST_FILL - 1));
		// Lines with bank swap, parser bank read back at the end of each
		for (int ln = 0; ln < NLINES; ln++)
			for (int f = 0; f < LINE_FRAMES; f++)
				if (f < LINE_FRAMES - 6)
					runFrame(1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0);
				else
					runFrame(1'b1, `SF_LIST_BASE + {3'd0, ~curFlip,
						7'(f - (LINE_FRAMES - 6))}, 1'b0, 1'b1, '0, 11'd1,
						f == LINE_FRAMES - 1);
		if (errCnt == 0)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			$display("Testbench failed");
			$fatal(1, "%0d checks failed", errCnt);
		end
	end

endmodule

// ==== spriteFast.f ====
+incdir+include
verilog/spriteFastPkg.sv
verilog/fastVram.sv
verilog/fastBusArbiter.sv
verilog/cpuPort.sv
verilog/spriteParser.sv
verilog/renderFetch.sv
verilog/spriteFast.sv
test/spriteFastTb.sv

// ==== Bender.yml ====
package:
  name: spriteFast

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/spriteFastPkg.sv
      - verilog/fastVram.sv
      - verilog/fastBusArbiter.sv
      - verilog/cpuPort.sv
      - verilog/spriteParser.sv
      - verilog/renderFetch.sv
      - verilog/spriteFast.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/spriteFastTb.sv
